/* Bender.yml */
package:
  name: rv32i_lsu

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rv32i_types.sv
      - source/ls_decode.sv
      - source/ls_execute.sv
      - source/mem_port.sv
      - source/load_align.sv
      - source/data_ram.sv
      - source/lsu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/lsu_tb.sv

/* filelist.f */
+incdir+source
source/rv32i_types.sv
source/ls_decode.sv
source/ls_execute.sv
source/mem_port.sv
source/load_align.sv
source/data_ram.sv
source/lsu_top.sv
tests/lsu_tb.sv

/* source/data_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data RAM, Wishbone classic slave with byte selects and registered ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module data_ram (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  rv32i_types::word_t       adr,
    input  rv32i_types::word_t       dat_w,
    input  rv32i_types::byte_mask_t  sel,
    output rv32i_types::word_t       dat_r,
    output logic                     ack
);

    rv32i_types::word_t        mem [`LSU_RAM_WORDS];
    logic [`LSU_RAM_AW-1:0]    idx;
    logic                      req;

    assign idx = adr[`LSU_RAM_AW+1:2];

    // a new request is one not yet acked
    assign req = cyc && stb && !ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (sel[i]) begin
                        mem[idx][8*i +: 8] <= dat_w[8*i +: 8];
                    end
                end
            end
            dat_r <= mem[idx];
        end
    end

endmodule

`default_nettype wire

/* source/load_align.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writeback stage: load lane extraction, extension and the result record
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module load_align (
    input  logic                      clk,
    input  logic                      reset,
    input  rv32i_types::mem_wb_reg_t  mem_wb,
    output logic                      out_valid,
    output rv32i_types::lsu_result_t  out_result
);

    rv32i_types::word_t shifted;
    rv32i_types::word_t value;
    logic               load_ok;

    // lane 0 holds the addressed byte after the shift
    assign shifted = mem_wb.rdata >> {mem_wb.addr[1:0], 3'b000};

    assign load_ok = mem_wb.mem_ctrl.mem_re && (|mem_wb.rmask)
                     && !mem_wb.misaligned && !mem_wb.illegal;

    always_comb begin
        value = '0;
        if (load_ok) begin
            unique case (mem_wb.mem_ctrl.funct3)
                rv32i_types::load_f3_lb:  value = {{24{shifted[7]}}, shifted[7:0]};
                rv32i_types::load_f3_lh:  value = {{16{shifted[15]}}, shifted[15:0]};
                rv32i_types::load_f3_lw:  value = shifted;
                rv32i_types::load_f3_lbu: value = {24'd0, shifted[7:0]};
                rv32i_types::load_f3_lhu: value = {16'd0, shifted[15:0]};
                default:                  value = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= mem_wb.valid;
        end
        if (mem_wb.valid) begin
            out_result.rd         <= mem_wb.rd;
            // stores and flagged entries never write rd
            out_result.rd_we      <= mem_wb.rd_we && load_ok;
            out_result.value      <= value;
            out_result.misaligned <= mem_wb.misaligned;
            out_result.illegal    <= mem_wb.illegal;
        end
    end

endmodule

`default_nettype wire

/* source/ls_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage: opcode, funct3 and immediate decode into the id_ex register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ls_decode (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  rv32i_types::word_t       in_inst,
    input  rv32i_types::word_t       in_rs1_v,
    input  rv32i_types::word_t       in_rs2_v,
    output logic                     in_ready,
    input  logic                     stall,
    output rv32i_types::id_ex_reg_t  id_ex
);

    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    rv32i_types::mem_ctrl_t ctrl;
    rv32i_types::word_t     imm;
    rv32i_types::reg_idx_t  rd;
    logic                   illegal;

    assign opcode   = in_inst[6:0];
    assign funct3   = in_inst[14:12];
    assign in_ready = ~stall;

    always_comb begin
        ctrl    = '0;
        imm     = '0;
        rd      = '0;
        illegal = 1'b1;
        ctrl.funct3 = funct3;
        if (opcode == op_load) begin
            // I-type immediate
            imm = {{20{in_inst[31]}}, in_inst[31:20]};
            rd  = in_inst[11:7];
            unique case (funct3)
                rv32i_types::load_f3_lb, rv32i_types::load_f3_lh,
                rv32i_types::load_f3_lw, rv32i_types::load_f3_lbu,
                rv32i_types::load_f3_lhu: begin
                    ctrl.mem_re = 1'b1;
                    illegal     = 1'b0;
                end
                default: illegal = 1'b1;
            endcase
        end else if (opcode == op_store) begin
            // S-type immediate, no destination
            imm = {{20{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
            unique case (funct3)
                rv32i_types::store_f3_sb, rv32i_types::store_f3_sh,
                rv32i_types::store_f3_sw: begin
                    ctrl.mem_we = 1'b1;
                    illegal     = 1'b0;
                end
                default: illegal = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else if (!stall) begin
            id_ex.valid <= in_valid;
        end
        if (!stall && in_valid) begin
            id_ex.rd       <= rd;
            id_ex.rd_we    <= ctrl.mem_re;
            id_ex.rs1_v    <= in_rs1_v;
            id_ex.rs2_v    <= in_rs2_v;
            id_ex.imm      <= imm;
            id_ex.mem_ctrl <= ctrl;
            id_ex.illegal  <= illegal;
        end
    end

endmodule

`default_nettype wire

/* source/ls_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage: address add and alignment check into the ex_mem register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ls_execute (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  rv32i_types::id_ex_reg_t   id_ex,
    output rv32i_types::ex_mem_reg_t  ex_mem
);

    rv32i_types::word_t addr;
    logic               half_access;
    logic               word_access;
    logic               misaligned;

    assign addr = id_ex.rs1_v + id_ex.imm;

    always_comb begin
        half_access = 1'b0;
        word_access = 1'b0;
        // store and load codes share 001 for half, 010 for word
        if (id_ex.mem_ctrl.mem_re || id_ex.mem_ctrl.mem_we) begin
            unique case (id_ex.mem_ctrl.funct3)
                rv32i_types::load_f3_lh, rv32i_types::load_f3_lhu: half_access = 1'b1;
                rv32i_types::load_f3_lw: word_access = 1'b1;
                default: ;
            endcase
        end
        misaligned = (half_access && addr[0]) || (word_access && (addr[1:0] != 2'b00));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else if (!stall) begin
            ex_mem.valid <= id_ex.valid;
        end
        if (!stall) begin
            ex_mem.rd         <= id_ex.rd;
            ex_mem.rd_we      <= id_ex.rd_we;
            ex_mem.mem_ctrl   <= id_ex.mem_ctrl;
            ex_mem.addr       <= addr;
            ex_mem.rs2_v      <= id_ex.rs2_v;
            ex_mem.misaligned <= misaligned;
            ex_mem.illegal    <= id_ex.illegal;
        end
    end

endmodule

`default_nettype wire

/* source/lsu_config.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU configuration: data RAM depth and word-address width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data RAM depth in 32-bit words
`define LSU_RAM_WORDS 256

// word-address width, log2 of the depth
`define LSU_RAM_AW 8

`endif

/* source/lsu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store path top: decode, execute, memory, writeback and data RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  rv32i_types::word_t        in_inst,
    input  rv32i_types::word_t        in_rs1_v,
    input  rv32i_types::word_t        in_rs2_v,
    output logic                      out_valid,
    output rv32i_types::lsu_result_t  out_result
);

    rv32i_types::id_ex_reg_t   id_ex;
    rv32i_types::ex_mem_reg_t  ex_mem;
    rv32i_types::mem_wb_reg_t  mem_wb;
    logic                      stall;

    // Wishbone between memory stage and RAM
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic                      wb_ack;
    rv32i_types::word_t        wb_adr;
    rv32i_types::word_t        wb_dat_w;
    rv32i_types::word_t        wb_dat_r;
    rv32i_types::byte_mask_t   wb_sel;

    ls_decode ls_decode_inst (
        .clk, .reset, .in_valid, .in_inst, .in_rs1_v, .in_rs2_v,
        .in_ready, .stall, .id_ex
    );

    ls_execute ls_execute_inst (.clk, .reset, .stall, .id_ex, .ex_mem);

    mem_port mem_port_inst (
        .clk, .reset, .ex_mem, .stall, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
        .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack, .mem_wb
    );

    load_align load_align_inst (.clk, .reset, .mem_wb, .out_valid, .out_result);

    data_ram data_ram_inst (
        .clk, .reset, .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .dat_w(wb_dat_w), .sel(wb_sel), .dat_r(wb_dat_r), .ack(wb_ack)
    );

endmodule

`default_nettype wire

/* source/mem_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory stage: byte lanes, write data and the Wishbone classic master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module mem_port (
    input  logic                      clk,
    input  logic                      reset,
    input  rv32i_types::ex_mem_reg_t  ex_mem,
    output logic                      stall,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output rv32i_types::word_t        wb_adr,
    output rv32i_types::word_t        wb_dat_w,
    output rv32i_types::byte_mask_t   wb_sel,
    input  rv32i_types::word_t        wb_dat_r,
    input  logic                      wb_ack,
    output rv32i_types::mem_wb_reg_t  mem_wb
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_t;

    state_t                   state;
    state_t                   state_next;
    rv32i_types::word_t       addr;
    rv32i_types::word_t       wdata;
    rv32i_types::byte_mask_t  rmask;
    rv32i_types::byte_mask_t  wmask;
    logic                     access;
    logic                     done;
    logic                     capture;

    assign addr = ex_mem.addr;

    always_comb begin
        rmask = '0;
        wmask = '0;
        wdata = '0;
        if (ex_mem.valid && !ex_mem.misaligned && !ex_mem.illegal) begin
            if (ex_mem.mem_ctrl.mem_we) begin
                unique case (ex_mem.mem_ctrl.funct3)
                    rv32i_types::store_f3_sb: begin
                        wmask = 4'b0001 << addr[1:0];
                        wdata[8*addr[1:0] +: 8] = ex_mem.rs2_v[7:0];
                    end
                    rv32i_types::store_f3_sh: begin
                        wmask = 4'b0011 << addr[1:0];
                        wdata[16*addr[1] +: 16] = ex_mem.rs2_v[15:0];
                    end
                    rv32i_types::store_f3_sw: begin
                        wmask = 4'b1111;
                        wdata = ex_mem.rs2_v;
                    end
                    default: ;
                endcase
            end
            if (ex_mem.mem_ctrl.mem_re) begin
                unique case (ex_mem.mem_ctrl.funct3)
                    rv32i_types::load_f3_lb, rv32i_types::load_f3_lbu:
                        rmask = 4'b0001 << addr[1:0];
                    rv32i_types::load_f3_lh, rv32i_types::load_f3_lhu:
                        rmask = 4'b0011 << addr[1:0];
                    rv32i_types::load_f3_lw:
                        rmask = 4'b1111;
                    default: ;
                endcase
            end
        end
    end

    // a bus cycle only for entries with a lane to touch
    assign access  = (|rmask) || (|wmask);
    assign done    = (state == st_busy) && wb_ack;
    assign capture = done || (ex_mem.valid && !access);
    assign stall   = access && !done;

    assign wb_cyc   = access;
    assign wb_stb   = access;
    assign wb_we    = |wmask;
    assign wb_adr   = {addr[31:2], 2'b00};
    assign wb_sel   = rmask | wmask;
    assign wb_dat_w = wdata;

    always_comb begin
        state_next = state;
        unique case (state)
            st_idle: if (access) state_next = st_busy;
            st_busy: if (wb_ack) state_next = st_idle;
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid <= capture;
        end
        if (capture) begin
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.rd_we      <= ex_mem.rd_we;
            mem_wb.mem_ctrl   <= ex_mem.mem_ctrl;
            mem_wb.addr       <= addr;
            mem_wb.rmask      <= rmask;
            mem_wb.rdata      <= done ? wb_dat_r : '0;
            mem_wb.misaligned <= ex_mem.misaligned;
            mem_wb.illegal    <= ex_mem.illegal;
        end
    end

endmodule

`default_nettype wire

/* source/rv32i_types.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I load/store types: widths, funct3 codes and pipeline stage records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv32i_types;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_mask_t;

    typedef enum logic [2:0] {
        load_f3_lb  = 3'b000,
        load_f3_lh  = 3'b001,
        load_f3_lw  = 3'b010,
        load_f3_lbu = 3'b100,
        load_f3_lhu = 3'b101
    } load_f3_t;

    typedef enum logic [2:0] {
        store_f3_sb = 3'b000,
        store_f3_sh = 3'b001,
        store_f3_sw = 3'b010
    } store_f3_t;

    typedef struct packed {
        logic       mem_re;
        logic       mem_we;
        logic [2:0] funct3;
    } mem_ctrl_t;

    typedef struct packed {
        logic      valid;
        reg_idx_t  rd;
        logic      rd_we;
        word_t     rs1_v;
        word_t     rs2_v;
        word_t     imm;
        mem_ctrl_t mem_ctrl;
        logic      illegal;
    } id_ex_reg_t;

    typedef struct packed {
        logic      valid;
        reg_idx_t  rd;
        logic      rd_we;
        mem_ctrl_t mem_ctrl;
        word_t     addr;
        word_t     rs2_v;
        logic      misaligned;
        logic      illegal;
    } ex_mem_reg_t;

    typedef struct packed {
        logic       valid;
        reg_idx_t   rd;
        logic       rd_we;
        mem_ctrl_t  mem_ctrl;
        word_t      addr;
        byte_mask_t rmask;
        word_t      rdata;
        logic       misaligned;
        logic       illegal;
    } mem_wb_reg_t;

    // one record per retired instruction
    typedef struct packed {
        reg_idx_t rd;
        logic     rd_we;
        word_t    value;
        logic     misaligned;
        logic     illegal;
    } lsu_result_t;

endpackage

`default_nettype wire

/* tests/lsu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store path testbench: instruction table checked against a RAM model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;

    typedef struct packed {
        rv32i_types::word_t       inst;
        rv32i_types::word_t       rs1_v;
        rv32i_types::word_t       rs2_v;
        rv32i_types::lsu_result_t expected;
    } entry_t;

    localparam int wait_limit = 50;

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    logic                     in_ready;
    rv32i_types::word_t       in_inst;
    rv32i_types::word_t       in_rs1_v;
    rv32i_types::word_t       in_rs2_v;
    logic                     out_valid;
    rv32i_types::lsu_result_t out_result;

    entry_t             table_q[$];
    rv32i_types::word_t model [`LSU_RAM_WORDS];

    lsu_top lsu_top_inst (
        .clk, .reset, .in_valid, .in_ready, .in_inst, .in_rs1_v, .in_rs2_v,
        .out_valid, .out_result
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: no %s within %0d cycles", $time, what, wait_limit);
        $display("TEST FAIL");
        $fatal(1, "run stopped on timeout");
    endtask

    task automatic check_word(input string name, input rv32i_types::word_t expected,
                              input rv32i_types::word_t actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    task automatic check_result(input rv32i_types::lsu_result_t expected,
                                input rv32i_types::lsu_result_t actual, input int idx);
        check_word($sformatf("out_result.value[%0d]", idx), expected.value, actual.value);
        if (actual !== expected) begin
            $display("Mismatch at %0t: out_result[%0d] expected %h, got %h",
                     $time, idx, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    // loads assemble bytes little endian from the model
    task automatic add_load(input logic [2:0] f3, input rv32i_types::reg_idx_t rd,
                            input rv32i_types::word_t rs1, input logic [11:0] imm);
        entry_t             e;
        rv32i_types::word_t addr;
        rv32i_types::word_t a;
        rv32i_types::word_t raw;
        int                 size;
        addr = rs1 + {{20{imm[11]}}, imm};
        size = 1 << f3[1:0];
        raw  = '0;
        e.inst        = {imm, 5'd1, f3, rd, 7'b0000011};
        e.rs1_v       = rs1;
        e.rs2_v       = '0;
        e.expected    = '0;
        e.expected.rd = rd;
        if ((addr & (size - 1)) != 0) begin
            e.expected.misaligned = 1'b1;
        end else begin
            for (int j = 0; j < size; j++) begin
                a = addr + j;
                raw[8*j +: 8] = model[a[`LSU_RAM_AW+1:2]][8*a[1:0] +: 8];
            end
            e.expected.rd_we = 1'b1;
            case (f3)
                3'b000:  e.expected.value = {{24{raw[7]}}, raw[7:0]};
                3'b001:  e.expected.value = {{16{raw[15]}}, raw[15:0]};
                default: e.expected.value = raw;
            endcase
        end
        table_q.push_back(e);
    endtask

    task automatic add_store(input logic [2:0] f3, input rv32i_types::word_t rs1,
                             input logic [11:0] imm, input rv32i_types::word_t data);
        entry_t             e;
        rv32i_types::word_t addr;
        rv32i_types::word_t a;
        int                 size;
        addr = rs1 + {{20{imm[11]}}, imm};
        size = 1 << f3[1:0];
        e.inst     = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
        e.rs1_v    = rs1;
        e.rs2_v    = data;
        e.expected = '0;
        if ((addr & (size - 1)) != 0) begin
            e.expected.misaligned = 1'b1;
        end else begin
            for (int j = 0; j < size; j++) begin
                a = addr + j;
                model[a[`LSU_RAM_AW+1:2]][8*a[1:0] +: 8] = data[8*j +: 8];
            end
        end
        table_q.push_back(e);
    endtask

    task automatic add_other(input rv32i_types::word_t inst);
        entry_t e;
        e.inst             = inst;
        e.rs1_v            = $urandom;
        e.rs2_v            = $urandom;
        e.expected         = '0;
        e.expected.illegal = 1'b1;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        rv32i_types::word_t base;
        logic [2:0]         load_codes [5];
        logic [2:0]         f3;
        int                 offset;
        base       = 32'h0000_0100;
        load_codes = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        // known contents for words 0x100 to 0x11c
        for (int w = 0; w < 8; w++) begin
            add_store(3'b010, base, 12'(4 * w), $urandom);
        end
        // word round trip through a negative offset
        add_store(3'b010, 32'h140, 12'hfe0, $urandom);
        add_load(3'b010, 5'd5, 32'h140, 12'hfe0);
        for (int off = 0; off < 4; off++) begin
            add_store(3'b000, base, 12'(4 + off), $urandom);
        end
        add_load(3'b010, 5'd6, base, 12'h004);
        add_store(3'b001, base, 12'h008, $urandom);
        add_store(3'b001, base, 12'h00a, $urandom);
        add_load(3'b010, 5'd7, base, 12'h008);
        // top bit set in every byte
        add_store(3'b010, base, 12'h00c, 32'h81f0_8c80);
        for (int off = 0; off < 4; off++) begin
            add_load(3'b000, 5'd8, base, 12'(12 + off));
            add_load(3'b100, 5'd9, base, 12'(12 + off));
        end
        for (int off = 0; off < 4; off += 2) begin
            add_load(3'b001, 5'd10, base, 12'(12 + off));
            add_load(3'b101, 5'd11, base, 12'(12 + off));
        end
        add_load(3'b001, 5'd12, base, 12'h011);
        add_load(3'b010, 5'd13, base, 12'h012);
        add_store(3'b001, base, 12'h013, $urandom);
        add_store(3'b010, base, 12'h012, $urandom);
        add_load(3'b010, 5'd14, base, 12'h010);
        // addi and add
        add_other(32'h0050_0093);
        add_other(32'h0020_81b3);
        for (int n = 0; n < 10; n++) begin
            f3     = $urandom % 2 ? load_codes[$urandom % 5] : 3'($urandom % 3);
            offset = 4 * ($urandom % 8);
            if (f3[1:0] == 2'b00) begin
                offset += $urandom % 4;
            end else if (f3[1:0] == 2'b01) begin
                offset += 2 * ($urandom % 2);
            end
            if (f3[2] || table_q.size() % 2 == 0) begin
                add_load(f3, 5'(16 + n), base, 12'(offset));
            end else begin
                add_store(f3, base, 12'(offset), $urandom);
            end
        end
    endtask

    task automatic drive_entries();
        int cycles;
        foreach (table_q[i]) begin
            in_valid = 1'b1;
            in_inst  = table_q[i].inst;
            in_rs1_v = table_q[i].rs1_v;
            in_rs2_v = table_q[i].rs2_v;
            cycles   = 0;
            while (!in_ready) begin
                @(posedge clk);
                #1;
                cycles++;
                if (cycles > wait_limit) begin
                    report_timeout("in_ready");
                end
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_results();
        int cycles;
        foreach (table_q[i]) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (!out_valid && cycles > wait_limit) begin
                    report_timeout("out_valid");
                end
            end while (!out_valid);
            check_result(table_q[i].expected, out_result, i);
        end
        // a repeated entry would show up here
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            if (out_valid) begin
                $display("Extra result at %0t after all %0d entries", $time, table_q.size());
                $display("TEST FAIL");
                $fatal(1, "run stopped on an extra result");
            end
        end
    endtask

    initial begin
        void'($urandom(32'h69cb));
        reset    = 1'b1;
        in_valid = 1'b0;
        in_inst  = '0;
        in_rs1_v = '0;
        in_rs2_v = '0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            drive_entries();
            collect_results();
        join
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
